/* cnnLoad_stim.mem */
// per layer: 4 bias words, 4 weight groups of 4 lanes (lane 0 first), layer 0 adds 8 features
// last word: expected final runLayer
// layer 0
b000 b001 b002 b003
c000 c001 c002 c003 c010 c011 c012 c013
c020 c021 c022 c023 c030 c031 c032 c033
d000 d001 d002 d003 d004 d005 d006 d007
// layer 1
b100 b101 b102 b103
c100 c101 c102 c103 c110 c111 c112 c113
c120 c121 c122 c123 c130 c131 c132 c133
// layer 2
b200 b201 b202 b203
c200 c201 c202 c203 c210 c211 c212 c213
c220 c221 c222 c223 c230 c231 c232 c233
// layer 3
b300 b301 b302 b303
c300 c301 c302 c303 c310 c311 c312 c313
c320 c321 c322 c323 c330 c331 c332 c333
// layer 4
b400 b401 b402 b403
c400 c401 c402 c403 c410 c411 c412 c413
c420 c421 c422 c423 c430 c431 c432 c433
// layer 5
b500 b501 b502 b503
c500 c501 c502 c503 c510 c511 c512 c513
c520 c521 c522 c523 c530 c531 c532 c533
// layer 6
b600 b601 b602 b603
c600 c601 c602 c603 c610 c611 c612 c613
c620 c621 c622 c623 c630 c631 c632 c633
// layer 7
b700 b701 b702 b703
c700 c701 c702 c703 c710 c711 c712 c713
c720 c721 c722 c723 c730 c731 c732 c733
// expected final layer
0007

/* project.f */
cnnPkg.sv
dualPortRam.sv
layerSequencer.sv
hostLoader.sv
cnnLoadTop.sv
tbClockGen.sv
cnnLoadTb.sv

/* Bender.yml */
package:
  name: cnn_load

sources:
  - cnnPkg.sv
  - dualPortRam.sv
  - layerSequencer.sv
  - hostLoader.sv
  - cnnLoadTop.sv
  - target: test
    files:
      - tbClockGen.sv
      - cnnLoadTb.sv

/* cnnLoadTb.sv */
module cnnLoadTb;
    import cnnPkg::*;

    localparam int weightLanes = 4;
    localparam int biasWords   = 4;
    localparam int weightWords = 4;
    localparam int layerWords  = 8;
    localparam int biasAw      = $clog2(biasWords);
    localparam int weightAw    = $clog2(weightWords);
    localparam int layerAw     = $clog2(layerWords);
    localparam int weightW     = weightLanes * $bits(dataWord);
    localparam int totalWords  = numLayers * (biasWords + weightWords * weightLanes) + layerWords;
    localparam int seedInit    = 32'h4290_af89;
    localparam int maxGap      = 3;   // most idle cycles between host words
    localparam int maxDelay    = 7;   // longest engine answer delay
    localparam int holdCycles  = 20;
    localparam int kindConv    = 0;
    localparam int kindPool    = 1;
    localparam int kindFc      = 2;
    localparam int timeoutCycles = 8 + 10 + totalWords * (maxGap + 1)
        + numLayers * 2 * (maxDelay + 8)
        + numLayers * (biasWords + weightWords + layerWords + 8) + holdCycles + 50;

    logic clk;
    logic rstN;
    logic ena;
    logic hostValid;
    logic convStatus;
    logic poolStatus;
    logic fcStatus;
    logic biasReadEn;
    logic weightReadEn;
    logic layerReadEn;
    logic [biasAw-1:0]   biasReadAddr;
    logic [weightAw-1:0] weightReadAddr;
    logic [layerAw-1:0]  layerReadAddr;
    logic [weightW-1:0]  weightReadData;
    logic hostRequest;
    logic convStart;
    logic poolStart;
    logic fcStart;
    logic netDone;
    dataWord   hostData;
    dataWord   biasReadData;
    dataWord   layerReadData;
    layerIndex runLayer;

    dataWord stim [totalWords + 1];  // host words and then the expected final layer
    integer  gapSeed   = seedInit;
    integer  delaySeed = seedInit;
    int valueErrors = 0;
    int otherErrors = 0;
    int cycleCount  = 0;
    int wordPtr     = 0;
    int loadCount   = 0;
    int gapLeft     = 0;
    int convSeen    = 0;
    int poolSeen    = 0;
    int fcSeen      = 0;
    logic prevRequest = 1'b0;
    logic prevConv    = 1'b0;
    logic prevPool    = 1'b0;
    logic prevFc      = 1'b0;
    logic doneAllowed = 1'b0;

    tbClockGen #(.period(10), .resetCycles(8)) clockGen (.clk(clk), .rstN(rstN));

    cnnLoadTop #(
        .weightLanes (weightLanes),
        .biasWords   (biasWords),
        .weightWords (weightWords),
        .layerWords  (layerWords)
    ) cnnLoadTop_i (.*);

    //////////////////////////////////////////////////////////////////////
    // helpers
    //////////////////////////////////////////////////////////////////////

    task automatic reportMismatch(input string name, input logic [63:0] expected,
                                  input logic [63:0] actual);
        $display("error %s expected %h actual %h", name, expected, actual);
        valueErrors++;
    endtask

    function automatic int layerLength(input int layer);
        return biasWords + weightWords * weightLanes + ((layer == 0) ? layerWords : 0);
    endfunction

    function automatic int layerBase(input int layer);
        int base;
        base = 0;
        for (int l = 0; l < layer; l++) begin
            base += layerLength(l);
        end
        return base;
    endfunction

    function automatic logic startLevel(input int kind);
        return (kind == kindConv) ? convStart : (kind == kindPool) ? poolStart : fcStart;
    endfunction

    task automatic setStatus(input int kind, input logic level);
        if (kind == kindConv) convStatus = level;
        else if (kind == kindPool) poolStatus = level;
        else fcStatus = level;
    endtask

    task automatic waitAnyStart(output int kind);
        while (!(convStart || poolStart || fcStart)) @(negedge clk);
        kind = convStart ? kindConv : poolStart ? kindPool : kindFc;
    endtask

    // engine model raising status after a random delay until the start falls
    task automatic finishEngine(input int kind);
        int delay;
        delay = $random(delaySeed) & maxDelay;
        repeat (delay) @(negedge clk);
        setStatus(kind, 1'b1);
        while (startLevel(kind)) @(negedge clk);
        setStatus(kind, 1'b0);
    endtask

    // read ports with data compared one cycle after the enable
    task automatic checkRams(input int layer);
        int base;
        logic [weightW-1:0] expW;
        base = layerBase(layer);
        for (int i = 0; i < biasWords; i++) begin
            biasReadEn   = 1'b1;
            biasReadAddr = biasAw'(i);
            @(negedge clk);
            biasReadEn = 1'b0;
            if (biasReadData !== stim[base + i])
                reportMismatch("biasReadData", stim[base + i], biasReadData);
        end
        for (int g = 0; g < weightWords; g++) begin
            for (int l = 0; l < weightLanes; l++) begin
                expW[l*16 +: 16] = stim[base + biasWords + g * weightLanes + l];  // lane 0 low
            end
            weightReadEn   = 1'b1;
            weightReadAddr = weightAw'(g);
            @(negedge clk);
            weightReadEn = 1'b0;
            if (weightReadData !== expW) reportMismatch("weightReadData", expW, weightReadData);
        end
        if (layer == 0) begin
            for (int i = 0; i < layerWords; i++) begin
                layerReadEn   = 1'b1;
                layerReadAddr = layerAw'(i);
                @(negedge clk);
                layerReadEn = 1'b0;
                if (layerReadData !== stim[base + biasWords + weightWords * weightLanes + i])
                    reportMismatch("layerReadData",
                                   stim[base + biasWords + weightWords * weightLanes + i],
                                   layerReadData);
            end
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // host feeder and monitors
    //////////////////////////////////////////////////////////////////////

    always @(negedge clk) begin
        if (prevRequest && !hostRequest) begin  // end of one load
            if (wordPtr != layerBase(loadCount) + layerLength(loadCount))
                reportMismatch("hostWordCount", layerBase(loadCount) + layerLength(loadCount),
                               wordPtr);
            loadCount++;
        end
        prevRequest = hostRequest;
        hostValid   = 1'b0;
        hostData    = 16'hdead;
        if (rstN && hostRequest === 1'b1 && wordPtr < totalWords) begin
            if (gapLeft > 0) begin
                gapLeft--;
            end else begin
                hostValid = 1'b1;
                hostData  = stim[wordPtr];
                wordPtr++;
                gapLeft = $random(gapSeed) & maxGap;
            end
        end else if (rstN && hostRequest === 1'b0) begin
            hostValid = cycleCount[0];  // junk the loader must drop
        end
    end

    always @(negedge clk) begin
        if (convStart && !prevConv) convSeen++;
        if (poolStart && !prevPool) poolSeen++;
        if (fcStart && !prevFc) fcSeen++;
        prevConv = convStart;
        prevPool = poolStart;
        prevFc   = fcStart;
        if (netDone === 1'b1 && !doneAllowed) begin
            $display("netDone went high before the last fc status");
            otherErrors++;
            doneAllowed = 1'b1;
        end
    end

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= timeoutCycles) begin
            $display("timeout: the run did not end within %0d cycles", timeoutCycles);
            $display("sim failed");
            $finish;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // main sequence
    //////////////////////////////////////////////////////////////////////

    initial begin
        int kind;
        layerIndex finalLayer;
        ena = 1'b0;
        hostValid = 1'b0;
        hostData = '0;
        {convStatus, poolStatus, fcStatus} = '0;
        {biasReadEn, weightReadEn, layerReadEn} = '0;
        biasReadAddr = '0;
        weightReadAddr = '0;
        layerReadAddr = '0;
        $readmemh("cnnLoad_stim.mem", stim);
        if (^stim[totalWords] === 1'bx) begin
            $display("stim file is missing or too short");
            otherErrors++;
        end

        @(posedge rstN);
        repeat (3) begin  // idle outputs while ena is still low
            @(negedge clk);
            if (hostRequest !== 1'b0) reportMismatch("hostRequest", 0, hostRequest);
            if ({convStart, poolStart, fcStart} !== 3'b000)
                reportMismatch("starts", 0, {convStart, poolStart, fcStart});
            if (netDone !== 1'b0) reportMismatch("netDone", 0, netDone);
            if (runLayer !== '0) reportMismatch("runLayer", 0, runLayer);
        end
        ena = 1'b1;

        for (int layer = 0; layer < numLayers; layer++) begin
            waitAnyStart(kind);
            if (kind != ((layer < numConvLayers) ? kindConv : kindFc)) begin
                $display("wrong engine started for layer %0d", layer);
                otherErrors++;
            end
            if (runLayer !== layerIndex'(layer)) reportMismatch("runLayer", layer, runLayer);
            checkRams(layer);
            finishEngine(kind);
            if (layer == numLayers - 1) doneAllowed = 1'b1;
            if (layer < numConvLayers) begin
                waitAnyStart(kind);
                if (kind != kindPool) begin
                    $display("no pool start after conv of layer %0d", layer);
                    otherErrors++;
                end
                finishEngine(kind);
            end
        end

        while (netDone !== 1'b1) @(negedge clk);
        finalLayer = stim[totalWords][3:0];
        if (runLayer !== finalLayer) reportMismatch("runLayer", finalLayer, runLayer);
        repeat (holdCycles) begin
            @(negedge clk);
            if (netDone !== 1'b1) reportMismatch("netDone", 1, netDone);
            if (runLayer !== finalLayer) reportMismatch("runLayer", finalLayer, runLayer);
        end
        if (convSeen != numConvLayers) reportMismatch("convStarts", numConvLayers, convSeen);
        if (poolSeen != numConvLayers) reportMismatch("poolStarts", numConvLayers, poolSeen);
        if (fcSeen != numLayers - numConvLayers)
            reportMismatch("fcStarts", numLayers - numConvLayers, fcSeen);
        if (wordPtr != totalWords) reportMismatch("hostWordsSent", totalWords, wordPtr);

        $display("errors: %0d wrong values, %0d other failures", valueErrors, otherErrors);
        if (valueErrors == 0 && otherErrors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

/* tbClockGen.sv */
module tbClockGen #(
    parameter int period      = 10,
    parameter int resetCycles = 8
) (
    output logic clk,
    output logic rstN
);

    initial begin
        clk = 1'b0;
        forever #(period / 2) clk = ~clk;
    end

    // reset low for resetCycles rising edges and released on a falling edge
    initial begin
        rstN = 1'b0;
        repeat (resetCycles) @(posedge clk);
        @(negedge clk);
        rstN = 1'b1;
    end

endmodule

/* cnnLoadTop.sv */
module cnnLoadTop #(
    parameter  int weightLanes = 4,
    parameter  int biasWords   = 4,
    parameter  int weightWords = 4,
    parameter  int layerWords  = 8,
    localparam int biasAw      = (biasWords > 1) ? $clog2(biasWords) : 1,
    localparam int weightAw    = (weightWords > 1) ? $clog2(weightWords) : 1,
    localparam int layerAw     = (layerWords > 1) ? $clog2(layerWords) : 1,
    localparam int weightW     = weightLanes * $bits(cnnPkg::dataWord)
) (
    input  logic                clk,
    input  logic                rstN,
    input  logic                ena,
    input  logic                hostValid,
    input  cnnPkg::dataWord     hostData,
    input  logic                convStatus,
    input  logic                poolStatus,
    input  logic                fcStatus,
    input  logic                biasReadEn,
    input  logic [biasAw-1:0]   biasReadAddr,
    input  logic                weightReadEn,
    input  logic [weightAw-1:0] weightReadAddr,
    input  logic                layerReadEn,
    input  logic [layerAw-1:0]  layerReadAddr,
    output logic                hostRequest,
    output cnnPkg::layerIndex   runLayer,
    output logic                convStart,
    output logic                poolStart,
    output logic                fcStart,
    output logic                netDone,
    output cnnPkg::dataWord     biasReadData,
    output logic [weightW-1:0]  weightReadData,
    output cnnPkg::dataWord     layerReadData
);
    import cnnPkg::*;

    logic                loadCmd;
    logic                dataReady;
    logic                biasWe;
    logic [biasAw-1:0]   biasAddr;
    dataWord             biasDin;
    logic                weightWe;
    logic [weightAw-1:0] weightAddr;
    logic [weightW-1:0]  weightDin;
    logic                layerWe;
    logic [layerAw-1:0]  layerAddr;
    dataWord             layerDin;

    //////////////////////////////////////////////////////////////////////
    // control
    //////////////////////////////////////////////////////////////////////

    layerSequencer sequencer (
        .clk        (clk),
        .rstN       (rstN),
        .ena        (ena),
        .dataReady  (dataReady),
        .convStatus (convStatus),
        .poolStatus (poolStatus),
        .fcStatus   (fcStatus),
        .loadCmd    (loadCmd),
        .runLayer   (runLayer),
        .convStart  (convStart),
        .poolStart  (poolStart),
        .fcStart    (fcStart),
        .netDone    (netDone)
    );

    hostLoader #(
        .weightLanes (weightLanes),
        .biasWords   (biasWords),
        .weightWords (weightWords),
        .layerWords  (layerWords)
    ) loader (
        .clk         (clk),
        .rstN        (rstN),
        .loadCmd     (loadCmd),
        .runLayer    (runLayer),
        .hostValid   (hostValid),
        .hostData    (hostData),
        .hostRequest (hostRequest),
        .dataReady   (dataReady),
        .biasWe      (biasWe),
        .biasAddr    (biasAddr),
        .biasDin     (biasDin),
        .weightWe    (weightWe),
        .weightAddr  (weightAddr),
        .weightDin   (weightDin),
        .layerWe     (layerWe),
        .layerAddr   (layerAddr),
        .layerDin    (layerDin)
    );

    //////////////////////////////////////////////////////////////////////
    // on-chip RAMs written by the loader and read by the engines
    //////////////////////////////////////////////////////////////////////

    dualPortRam #(.dataWidth($bits(dataWord)), .depth(biasWords)) biasRam (
        .clk       (clk),
        .we        (biasWe),
        .writeAddr (biasAddr),
        .din       (biasDin),
        .re        (biasReadEn),
        .readAddr  (biasReadAddr),
        .dout      (biasReadData)
    );

    dualPortRam #(.dataWidth(weightW), .depth(weightWords)) weightRam (
        .clk       (clk),
        .we        (weightWe),
        .writeAddr (weightAddr),
        .din       (weightDin),
        .re        (weightReadEn),
        .readAddr  (weightReadAddr),
        .dout      (weightReadData)
    );

    // first layer input features
    dualPortRam #(.dataWidth($bits(dataWord)), .depth(layerWords)) layerRam (
        .clk       (clk),
        .we        (layerWe),
        .writeAddr (layerAddr),
        .din       (layerDin),
        .re        (layerReadEn),
        .readAddr  (layerReadAddr),
        .dout      (layerReadData)
    );

endmodule

/* hostLoader.sv */
module hostLoader #(
    parameter  int weightLanes = 4,
    parameter  int biasWords   = 4,
    parameter  int weightWords = 4,
    parameter  int layerWords  = 8,
    localparam int biasAw      = (biasWords > 1) ? $clog2(biasWords) : 1,
    localparam int weightAw    = (weightWords > 1) ? $clog2(weightWords) : 1,
    localparam int layerAw     = (layerWords > 1) ? $clog2(layerWords) : 1,
    localparam int weightW     = weightLanes * $bits(cnnPkg::dataWord)
) (
    input  logic                clk,
    input  logic                rstN,
    input  logic                loadCmd,
    input  cnnPkg::layerIndex   runLayer,
    input  logic                hostValid,
    input  cnnPkg::dataWord     hostData,
    output logic                hostRequest,
    output logic                dataReady,
    output logic                biasWe,
    output logic [biasAw-1:0]   biasAddr,
    output cnnPkg::dataWord     biasDin,
    output logic                weightWe,
    output logic [weightAw-1:0] weightAddr,
    output logic [weightW-1:0]  weightDin,
    output logic                layerWe,
    output logic [layerAw-1:0]  layerAddr,
    output cnnPkg::dataWord     layerDin
);
    import cnnPkg::*;

    localparam int wordW    = $bits(dataWord);
    localparam int maxBW    = (biasWords > weightWords) ? biasWords : weightWords;
    localparam int maxWords = (maxBW > layerWords) ? maxBW : layerWords;
    localparam int cntW     = (maxWords > 1) ? $clog2(maxWords) : 1;
    localparam int laneW    = (weightLanes > 1) ? $clog2(weightLanes) : 1;

    typedef enum logic [1:0] {pIdle, pBias, pWeight, pLayer} loadPhase;

    loadPhase                  phase;
    logic [cntW-1:0]           wordCnt;    // word index inside the phase
    logic [laneW-1:0]          laneCnt;
    logic [weightW-1:0]        laneShift;  // lane 0 ends up in the low bits
    logic [weightW+wordW-1:0]  laneNext;
    logic                      take;
    logic                      lastBias;
    logic                      lastLane;
    logic                      lastGroup;
    logic                      lastLayer;
    logic                      lastWrite;  // final RAM write of this layer

    assign take      = hostValid && hostRequest;  // words outside a request are dropped
    assign laneNext  = {hostData, laneShift};
    assign lastBias  = wordCnt == cntW'(biasWords - 1);
    assign lastLane  = laneCnt == laneW'(weightLanes - 1);
    assign lastGroup = wordCnt == cntW'(weightWords - 1);
    assign lastLayer = wordCnt == cntW'(layerWords - 1);

    //////////////////////////////////////////////////////////////////////
    // phase and counters
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rstN) begin
            phase       <= pIdle;
            wordCnt     <= '0;
            laneCnt     <= '0;
            hostRequest <= 1'b0;
            biasWe      <= 1'b0;
            weightWe    <= 1'b0;
            layerWe     <= 1'b0;
            lastWrite   <= 1'b0;
            dataReady   <= 1'b0;
        end else begin
            biasWe    <= 1'b0;
            weightWe  <= 1'b0;
            layerWe   <= 1'b0;
            lastWrite <= 1'b0;
            dataReady <= lastWrite;  // one cycle after the last write
            unique case (phase)
                pIdle: begin
                    if (loadCmd) begin
                        phase       <= pBias;
                        wordCnt     <= '0;
                        laneCnt     <= '0;
                        hostRequest <= 1'b1;
                    end
                end
                pBias: begin
                    if (take) begin
                        biasWe <= 1'b1;
                        if (lastBias) begin
                            wordCnt <= '0;
                            phase   <= pWeight;
                        end else begin
                            wordCnt <= wordCnt + 1'b1;
                        end
                    end
                end
                pWeight: begin
                    if (take && !lastLane) begin
                        laneCnt <= laneCnt + 1'b1;
                    end else if (take) begin
                        weightWe <= 1'b1;  // group complete
                        laneCnt  <= '0;
                        if (!lastGroup) begin
                            wordCnt <= wordCnt + 1'b1;
                        end else if (runLayer == '0) begin
                            wordCnt <= '0;
                            phase   <= pLayer;  // input features for first layer only
                        end else begin
                            phase       <= pIdle;
                            hostRequest <= 1'b0;
                            lastWrite   <= 1'b1;
                        end
                    end
                end
                pLayer: begin
                    if (take) begin
                        layerWe <= 1'b1;
                        if (lastLayer) begin
                            phase       <= pIdle;
                            hostRequest <= 1'b0;
                            lastWrite   <= 1'b1;
                        end else begin
                            wordCnt <= wordCnt + 1'b1;
                        end
                    end
                end
                default: phase <= pIdle;
            endcase
        end
    end

    //////////////////////////////////////////////////////////////////////
    // write payload
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (take) begin
            biasAddr   <= biasAw'(wordCnt);
            biasDin    <= hostData;
            weightAddr <= weightAw'(wordCnt);
            layerAddr  <= layerAw'(wordCnt);
            layerDin   <= hostData;
            laneShift  <= laneNext[weightW+wordW-1:wordW];  // newest word enters at top
        end
    end

    assign weightDin = laneShift;

    requestNotReady: assert property (
        @(posedge clk) disable iff (!rstN)
        !(hostRequest && dataReady)
    ) else $error("hostRequest and dataReady high together");

endmodule

/* layerSequencer.sv */
module layerSequencer (
    input  logic              clk,
    input  logic              rstN,
    input  logic              ena,
    input  logic              dataReady,
    input  logic              convStatus,
    input  logic              poolStatus,
    input  logic              fcStatus,
    output logic              loadCmd,
    output cnnPkg::layerIndex runLayer,
    output logic              convStart,
    output logic              poolStart,
    output logic              fcStart,
    output logic              netDone
);
    import cnnPkg::*;

    seqState state;
    seqState nextState;
    logic    loadReady;  // dataReady already seen in this load
    logic    lastLayer;
    logic    convLayer;

    assign lastLayer = runLayer == layerIndex'(numLayers - 1);
    assign convLayer = runLayer < layerIndex'(numConvLayers);

    //////////////////////////////////////////////////////////////////////
    // next state
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        nextState = state;
        if (ena) begin  // ena low freezes the walk
            unique case (state)
                sIdle: nextState = sLoad;
                sLoad: begin
                    if (dataReady || loadReady) begin
                        nextState = convLayer ? sConv : sFc;
                    end
                end
                sConv: if (convStatus) nextState = sPool;
                sPool: if (poolStatus) nextState = sNext;
                sFc:   if (fcStatus) nextState = sNext;
                sNext: nextState = lastLayer ? sDone : sLoad;
                sDone: nextState = sDone;  // held until reset
                default: nextState = sIdle;
            endcase
        end
    end

    //////////////////////////////////////////////////////////////////////
    // state, layer count and load command
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rstN) begin
            state     <= sIdle;
            runLayer  <= '0;
            loadCmd   <= 1'b0;
            loadReady <= 1'b0;
        end else begin
            state   <= nextState;
            loadCmd <= (nextState == sLoad) && (state != sLoad);  // one pulse per load

            if (state == sNext && nextState == sLoad) begin
                runLayer <= runLayer + 1'b1;
            end

            // keep a dataReady that lands while ena is low
            if (state != sLoad || nextState != sLoad) begin
                loadReady <= 1'b0;
            end else if (dataReady) begin
                loadReady <= 1'b1;
            end
        end
    end

    // engine starts are levels for the whole state
    assign convStart = state == sConv;
    assign poolStart = state == sPool;
    assign fcStart   = state == sFc;
    assign netDone   = state == sDone;

    //////////////////////////////////////////////////////////////////////
    // checks
    //////////////////////////////////////////////////////////////////////

    startExclusive: assert property (
        @(posedge clk) disable iff (!rstN)
        $onehot0({convStart, poolStart, fcStart})
    ) else $error("more than one engine start high");

    // load command only on the first cycle of a load
    loadCmdOnEntry: assert property (
        @(posedge clk) disable iff (!rstN)
        loadCmd |-> (state == sLoad) && ($past(state) != sLoad)
    ) else $error("loadCmd outside sLoad entry");

endmodule

/* dualPortRam.sv */
module dualPortRam #(
    parameter  int dataWidth = 16,
    parameter  int depth     = 16,
    localparam int addrW     = (depth > 1) ? $clog2(depth) : 1
) (
    input  logic                 clk,
    input  logic                 we,
    input  logic [addrW-1:0]     writeAddr,
    input  logic [dataWidth-1:0] din,
    input  logic                 re,
    input  logic [addrW-1:0]     readAddr,
    output logic [dataWidth-1:0] dout
);

    logic [dataWidth-1:0] mem [depth];

    // loader side
    always_ff @(posedge clk) begin
        if (we) begin
            mem[writeAddr] <= din;
        end
    end

    // engine side with data one cycle after re
    always_ff @(posedge clk) begin
        if (re) begin
            dout <= mem[readAddr];
        end
    end

endmodule

/* cnnPkg.sv */
package cnnPkg;

    //////////////////////////////////////////////////////////////////////
    // word types
    //////////////////////////////////////////////////////////////////////

    // 16-bit fixed point and also one weight lane
    typedef logic [15:0] dataWord;

    // layer number as seen on runLayer
    typedef logic [3:0] layerIndex;

    //////////////////////////////////////////////////////////////////////
    // network shape
    //////////////////////////////////////////////////////////////////////

    parameter int numLayers     = 8;  // conv1..conv5 then fc6..fc8
    parameter int numConvLayers = 5;  // layers below this run conv then pool

    //////////////////////////////////////////////////////////////////////
    // global controller states
    //////////////////////////////////////////////////////////////////////

    typedef enum logic [2:0] {
        sIdle,  // waiting for ena after reset
        sLoad,  // host loader filling bias/weight/layer RAMs
        sConv,  // conv engine running
        sPool,  // pool engine running
        sFc,    // fc engine running
        sNext,  // step to next layer
        sDone   // whole network finished
    } seqState;

endpackage
